/* Bender.yml */
package:
  name: stm_subsystem

sources:
  - rtl/stm_pkg.sv
  - rtl/stm_timer.sv
  - rtl/stm_swapchain.sv
  - rtl/stm_sequencer.sv
  - rtl/stm_gain_lane.sv
  - rtl/stm_serializer.sv
  - rtl/stm_top.sv
  - target: simulation
    files:
      - verification/stm_assertions.sv
      - verification/stm_tb.sv

/* rtl/stm_gain_lane.sv */
`timescale 1ns/1ps
module stm_gain_lane
  import stm_pkg::*;
#(
  parameter int DEPTH   = 256,
  parameter int LANE_ID = 0,
  parameter int LANE_W  = 2
) (
  input  logic              CLK,
  input  logic              wr_en,
  input  logic [LANE_W-1:0] wr_lane,
  input  segment_t          wr_segment,
  input  idx_t              wr_addr,
  input  intensity_t        wr_intensity,
  input  phase_t            wr_phase,
  input  logic              start,
  input  idx_t              seq_idx,
  input  segment_t          seq_segment,
  output intensity_t        intensity,
  output phase_t            phase
);

  localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // One bank per segment
  intensity_t int_mem   [2][DEPTH];
  phase_t     phase_mem [2][DEPTH];

  always_ff @(posedge CLK) begin
    if (wr_en && (wr_lane == LANE_ID)) begin
      int_mem[wr_segment][wr_addr[ADDR_W-1:0]]   <= wr_intensity;
      phase_mem[wr_segment][wr_addr[ADDR_W-1:0]] <= wr_phase;
    end
  end

  always_ff @(posedge CLK) begin
    if (start) begin
      intensity <= int_mem[seq_segment][seq_idx[ADDR_W-1:0]];
      phase     <= phase_mem[seq_segment][seq_idx[ADDR_W-1:0]];
    end
  end

endmodule

/* rtl/stm_pkg.sv */
package stm_pkg;

  // Pattern position and timing
  typedef logic [15:0] idx_t;
  typedef logic [15:0] cycle_t;
  typedef logic [15:0] freq_div_t;

  // All ones plays forever
  typedef logic [15:0] rep_t;

  // Per transducer drive values
  typedef logic [7:0] intensity_t;
  typedef logic [7:0] phase_t;

  typedef logic segment_t;

  typedef enum logic {
    swap_run,
    swap_stopped
  } swap_state_t;

endpackage

/* rtl/stm_sequencer.sv */
`timescale 1ns/1ps
module stm_sequencer
  import stm_pkg::*;
(
  input  logic     CLK,
  input  logic     rst_n,
  input  logic     update,
  input  segment_t segment,
  input  idx_t     idx,
  input  logic     stop,
  output logic     start,
  output idx_t     seq_idx,
  output segment_t seq_segment,
  output idx_t     dbg_idx,
  output segment_t dbg_segment
);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      start       <= 1'b0;
      seq_idx     <= '0;
      seq_segment <= '0;
    end else begin
      start <= update;
      // Position is frozen once the sequence has stopped
      if (update && !stop) begin
        seq_idx     <= idx;
        seq_segment <= segment;
      end
    end
  end

  assign dbg_idx     = seq_idx;
  assign dbg_segment = seq_segment;

endmodule

/* rtl/stm_serializer.sv */
`timescale 1ns/1ps
module stm_serializer
  import stm_pkg::*;
#(
  parameter int LANES = 4
) (
  input  logic                   CLK,
  input  logic                   rst_n,
  input  logic                   load,
  input  intensity_t [LANES-1:0] lane_intensity,
  input  phase_t     [LANES-1:0] lane_phase,
  output intensity_t             intensity,
  output phase_t                 phase,
  output logic                   dout_valid
);

  localparam int CNT_W = $clog2(LANES + 1);

  intensity_t [LANES-1:0] int_sr;
  phase_t     [LANES-1:0] phase_sr;
  logic [CNT_W-1:0]       remaining;
  logic                   load_d;

  // Lane memories answer one cycle after start
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      load_d    <= 1'b0;
      remaining <= '0;
    end else begin
      load_d <= load;
      if (load_d) begin
        remaining <= CNT_W'(LANES);
      end else if (remaining != '0) begin
        remaining <= remaining - 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (load_d) begin
      int_sr   <= lane_intensity;
      phase_sr <= lane_phase;
    end else begin
      for (int i = 0; i < LANES - 1; i++) begin
        int_sr[i]   <= int_sr[i+1];
        phase_sr[i] <= phase_sr[i+1];
      end
    end
  end

  // Lane 0 leaves first
  assign intensity  = int_sr[0];
  assign phase      = phase_sr[0];
  assign dout_valid = (remaining != '0);

endmodule

/* rtl/stm_swapchain.sv */
`timescale 1ns/1ps
module stm_swapchain
  import stm_pkg::*;
(
  input  logic     CLK,
  input  logic     rst_n,
  input  logic     settings_applied,
  input  segment_t req_segment,
  input  rep_t     rep_0,
  input  rep_t     rep_1,
  input  idx_t     idx_0,
  input  idx_t     idx_1,
  input  cycle_t   cycle_0,
  input  cycle_t   cycle_1,
  output segment_t segment,
  output idx_t     idx,
  output logic     stop
);

  swap_state_t state;
  segment_t    segment_q;
  rep_t        rep_q [2];
  rep_t        loop_cnt;
  idx_t        last_idx;
  idx_t        idx_prev;

  idx_t idx_sel;
  logic wrap;
  logic final_loop;

  assign idx_sel = segment_q ? idx_1 : idx_0;

  // A wrap is the step from the last index back to the first
  assign wrap = (state == swap_run) && (idx_prev == last_idx) && (idx_sel != idx_prev);

  assign final_loop = wrap && (rep_q[segment_q] != '1) && (loop_cnt == rep_q[segment_q]);

  // Hold the last entry already on the wrapping cycle so no index 0 leaks out
  assign idx     = (state == swap_stopped || final_loop) ? last_idx : idx_sel;
  assign stop    = (state == swap_stopped);
  assign segment = segment_q;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state     <= swap_stopped;
      segment_q <= '0;
      rep_q[0]  <= '0;
      rep_q[1]  <= '0;
      loop_cnt  <= '0;
      last_idx  <= '0;
      idx_prev  <= '0;
    end else if (settings_applied) begin
      state     <= swap_run;
      segment_q <= req_segment;
      rep_q[0]  <= rep_0;
      rep_q[1]  <= rep_1;
      loop_cnt  <= '0;
      last_idx  <= (req_segment ? cycle_1 : cycle_0) - 16'd1;
      idx_prev  <= '0;
    end else begin
      case (state)
        swap_run: begin
          idx_prev <= idx_sel;
          if (final_loop) begin
            state <= swap_stopped;
          end else if (wrap) begin
            loop_cnt <= loop_cnt + 16'd1;
          end
        end
        default: begin
          // Wait for the next settings update
        end
      endcase
    end
  end

endmodule

/* rtl/stm_timer.sv */
`timescale 1ns/1ps
module stm_timer
  import stm_pkg::*;
(
  input  logic      CLK,
  input  logic      rst_n,
  input  logic      settings_update,
  input  cycle_t    cycle_0,
  input  freq_div_t freq_div_0,
  input  cycle_t    cycle_1,
  input  freq_div_t freq_div_1,
  output idx_t      idx_0,
  output idx_t      idx_1,
  output logic      settings_applied
);

  cycle_t    cycle_q    [2];
  freq_div_t freq_div_q [2];
  freq_div_t div_cnt    [2];
  idx_t      idx_q      [2];
  logic      active;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      active           <= 1'b0;
      settings_applied <= 1'b0;
      for (int s = 0; s < 2; s++) begin
        cycle_q[s]    <= '0;
        freq_div_q[s] <= '0;
        div_cnt[s]    <= '0;
        idx_q[s]      <= '0;
      end
    end else begin
      settings_applied <= settings_update;
      if (settings_update) begin
        active        <= 1'b1;
        cycle_q[0]    <= cycle_0;
        cycle_q[1]    <= cycle_1;
        freq_div_q[0] <= freq_div_0;
        freq_div_q[1] <= freq_div_1;
        for (int s = 0; s < 2; s++) begin
          div_cnt[s] <= '0;
          idx_q[s]   <= '0;
        end
      end else if (active) begin
        // Each segment steps on its own divider
        for (int s = 0; s < 2; s++) begin
          if (div_cnt[s] == freq_div_q[s] - 16'd1) begin
            div_cnt[s] <= '0;
            if (idx_q[s] == cycle_q[s] - 16'd1) begin
              idx_q[s] <= '0;
            end else begin
              idx_q[s] <= idx_q[s] + 16'd1;
            end
          end else begin
            div_cnt[s] <= div_cnt[s] + 16'd1;
          end
        end
      end
    end
  end

  assign idx_0 = idx_q[0];
  assign idx_1 = idx_q[1];

endmodule

/* rtl/stm_top.sv */
`timescale 1ns/1ps
module stm_top
  import stm_pkg::*;
#(
  parameter  int LANES  = 4,
  parameter  int DEPTH  = 256,
  localparam int LANE_W = (LANES > 1) ? $clog2(LANES) : 1
) (
  input  logic              CLK,
  input  logic              rst_n,
  input  logic              settings_update,
  input  cycle_t            cycle_0,
  input  freq_div_t         freq_div_0,
  input  cycle_t            cycle_1,
  input  freq_div_t         freq_div_1,
  input  segment_t          req_segment,
  input  rep_t              rep_0,
  input  rep_t              rep_1,
  input  logic              update,
  input  logic              wr_en,
  input  logic [LANE_W-1:0] wr_lane,
  input  segment_t          wr_segment,
  input  idx_t              wr_addr,
  input  intensity_t        wr_intensity,
  input  phase_t            wr_phase,
  output intensity_t        intensity,
  output phase_t            phase,
  output logic              dout_valid,
  output idx_t              dbg_idx,
  output segment_t          dbg_segment
);

  idx_t     timer_idx_0;
  idx_t     timer_idx_1;
  logic     settings_applied;
  segment_t sw_segment;
  idx_t     sw_idx;
  logic     sw_stop;
  logic     start;
  idx_t     seq_idx;
  segment_t seq_segment;

  intensity_t [LANES-1:0] lane_intensity;
  phase_t     [LANES-1:0] lane_phase;

  stm_timer u_timer (
    .CLK              (CLK),
    .rst_n            (rst_n),
    .settings_update  (settings_update),
    .cycle_0          (cycle_0),
    .freq_div_0       (freq_div_0),
    .cycle_1          (cycle_1),
    .freq_div_1       (freq_div_1),
    .idx_0            (timer_idx_0),
    .idx_1            (timer_idx_1),
    .settings_applied (settings_applied)
  );

  stm_swapchain u_swapchain (
    .CLK              (CLK),
    .rst_n            (rst_n),
    .settings_applied (settings_applied),
    .req_segment      (req_segment),
    .rep_0            (rep_0),
    .rep_1            (rep_1),
    .idx_0            (timer_idx_0),
    .idx_1            (timer_idx_1),
    .cycle_0          (cycle_0),
    .cycle_1          (cycle_1),
    .segment          (sw_segment),
    .idx              (sw_idx),
    .stop             (sw_stop)
  );

  stm_sequencer u_sequencer (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .update      (update),
    .segment     (sw_segment),
    .idx         (sw_idx),
    .stop        (sw_stop),
    .start       (start),
    .seq_idx     (seq_idx),
    .seq_segment (seq_segment),
    .dbg_idx     (dbg_idx),
    .dbg_segment (dbg_segment)
  );

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    stm_gain_lane #(
      .DEPTH   (DEPTH),
      .LANE_ID (i),
      .LANE_W  (LANE_W)
    ) u_lane (
      .CLK          (CLK),
      .wr_en        (wr_en),
      .wr_lane      (wr_lane),
      .wr_segment   (wr_segment),
      .wr_addr      (wr_addr),
      .wr_intensity (wr_intensity),
      .wr_phase     (wr_phase),
      .start        (start),
      .seq_idx      (seq_idx),
      .seq_segment  (seq_segment),
      .intensity    (lane_intensity[i]),
      .phase        (lane_phase[i])
    );
  end

  stm_serializer #(
    .LANES (LANES)
  ) u_serializer (
    .CLK            (CLK),
    .rst_n          (rst_n),
    .load           (start),
    .lane_intensity (lane_intensity),
    .lane_phase     (lane_phase),
    .intensity      (intensity),
    .phase          (phase),
    .dout_valid     (dout_valid)
  );

endmodule

/* sources.f */
rtl/stm_pkg.sv
rtl/stm_timer.sv
rtl/stm_swapchain.sv
rtl/stm_sequencer.sv
rtl/stm_gain_lane.sv
rtl/stm_serializer.sv
rtl/stm_top.sv
verification/stm_assertions.sv
verification/stm_tb.sv

/* verification/stm_assertions.sv */
`timescale 1ns/1ps
module stm_assertions
  import stm_pkg::*;
#(
  parameter int LANES = 4
) (
  input logic     CLK,
  input logic     rst_n,
  input logic     update,
  input logic     sw_stop,
  input segment_t sw_segment,
  input cycle_t   cycle_0,
  input cycle_t   cycle_1,
  input logic     dout_valid,
  input idx_t     dbg_idx
);

  int     valid_run;
  logic   seen_update;
  cycle_t lat_cycle;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      valid_run   <= 0;
      seen_update <= 1'b0;
      lat_cycle   <= '1;
    end else begin
      valid_run <= dout_valid ? valid_run + 1 : 0;
      if (update) begin
        seen_update <= 1'b1;
      end
      // Cycle length of the segment the sequencer latched from
      if (update && !sw_stop) begin
        lat_cycle <= sw_segment ? cycle_1 : cycle_0;
      end
    end
  end

  a_burst_len: assert property (@(posedge CLK) disable iff (!rst_n)
    dout_valid |-> (valid_run < LANES))
    else $error("dout_valid high for more than %0d cycles", LANES);

  a_quiet_until_update: assert property (@(posedge CLK) disable iff (!rst_n)
    !seen_update |-> !dout_valid)
    else $error("dout_valid high before the first update");

  a_idx_range: assert property (@(posedge CLK) disable iff (!rst_n)
    dbg_idx < lat_cycle)
    else $error("dbg_idx %0d not below cycle %0d", dbg_idx, lat_cycle);

endmodule

bind stm_top stm_assertions #(
  .LANES (LANES)
) u_assertions (
  .CLK        (CLK),
  .rst_n      (rst_n),
  .update     (update),
  .sw_stop    (sw_stop),
  .sw_segment (sw_segment),
  .cycle_0    (cycle_0),
  .cycle_1    (cycle_1),
  .dout_valid (dout_valid),
  .dbg_idx    (dbg_idx)
);

/* verification/stm_tb.sv */
`timescale 1ns/1ps
module stm_tb
  import stm_pkg::*;
();

  localparam int LANES        = 4;
  localparam int DEPTH        = 256;
  localparam int LANE_W       = $clog2(LANES);
  localparam int MAXC         = 32;
  localparam int N_ROUNDS     = 6;
  localparam int N_UPD        = 10;
  localparam int MAX_GAP      = 20;
  localparam int N_STOP       = 4;
  localparam int N_STOP_UPD   = 25;
  localparam int STOP_GAP_MAX = 9;
  localparam int WRITE_EDGES  = 2 * LANES * MAXC;
  localparam int STEP_EDGES   = N_ROUNDS * (8 + N_UPD * MAX_GAP);
  localparam int STOP_EDGES   = N_STOP * (8 + N_STOP_UPD * STOP_GAP_MAX);
  localparam int TIMEOUT      = 2 * (10 + WRITE_EDGES + STEP_EDGES + STOP_EDGES) + 100;

  logic              CLK;
  logic              rst_n;
  logic              settings_update;
  cycle_t            cycle_0;
  freq_div_t         freq_div_0;
  cycle_t            cycle_1;
  freq_div_t         freq_div_1;
  segment_t          req_segment;
  rep_t              rep_0;
  rep_t              rep_1;
  logic              update;
  logic              wr_en;
  logic [LANE_W-1:0] wr_lane;
  segment_t          wr_segment;
  idx_t              wr_addr;
  intensity_t        wr_intensity;
  phase_t            wr_phase;
  intensity_t        intensity;
  phase_t            phase;
  logic              dout_valid;
  idx_t              dbg_idx;
  segment_t          dbg_segment;

  // Reference model state
  intensity_t mdl_int [2][LANES][MAXC];
  phase_t     mdl_ph  [2][LANES][MAXC];
  cycle_t     mdl_cycle [2];
  freq_div_t  mdl_fd [2];
  rep_t       mdl_rep [2];
  segment_t   mdl_seg;
  idx_t       mdl_seq_idx;
  segment_t   mdl_seq_seg;
  int         set_edge;

  // Expected burst words and the edge that each one follows
  int         exp_edge [$];
  int         exp_lane [$];
  intensity_t exp_int [$];
  phase_t     exp_ph [$];

  int     edge_cnt = 0;
  int     n_errors = 0;
  int     n_checks = 0;
  integer seed;

  stm_top #(
    .LANES (LANES),
    .DEPTH (DEPTH)
  ) dut0 (
    .CLK             (CLK),
    .rst_n           (rst_n),
    .settings_update (settings_update),
    .cycle_0         (cycle_0),
    .freq_div_0      (freq_div_0),
    .cycle_1         (cycle_1),
    .freq_div_1      (freq_div_1),
    .req_segment     (req_segment),
    .rep_0           (rep_0),
    .rep_1           (rep_1),
    .update          (update),
    .wr_en           (wr_en),
    .wr_lane         (wr_lane),
    .wr_segment      (wr_segment),
    .wr_addr         (wr_addr),
    .wr_intensity    (wr_intensity),
    .wr_phase        (wr_phase),
    .intensity       (intensity),
    .phase           (phase),
    .dout_valid      (dout_valid),
    .dbg_idx         (dbg_idx),
    .dbg_segment     (dbg_segment)
  );

  initial CLK = 1'b0;
  always #10 CLK = ~CLK;

  always @(posedge CLK) begin
    edge_cnt <= edge_cnt + 1;
  end

  always @(posedge CLK) begin
    if (edge_cnt >= TIMEOUT) begin
      $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT);
      $display("Verification failed");
      $finish;
    end
  end

  function automatic int rand_range(int lo, int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  // Step count at which the final loop ends or -1 when playing forever
  function automatic longint stop_point();
    if (mdl_rep[mdl_seg] == '1) begin
      return -1;
    end
    return (longint'(mdl_rep[mdl_seg]) + 1) * longint'(mdl_fd[mdl_seg])
           * longint'(mdl_cycle[mdl_seg]);
  endfunction

  function automatic idx_t model_idx(int m);
    int     c;
    int     f;
    longint sp;
    c  = int'(mdl_cycle[mdl_seg]);
    f  = int'(mdl_fd[mdl_seg]);
    sp = stop_point();
    if (sp >= 0 && m >= sp) begin
      return idx_t'(c - 1);
    end
    return idx_t'((m / f) % c);
  endfunction

  function automatic bit model_stop(int m);
    longint sp;
    sp = stop_point();
    return (sp >= 0) && (m > sp);
  endfunction

  task automatic step();
    @(posedge CLK);
    #2;
  endtask

  task automatic load_settings(cycle_t c0, freq_div_t f0, cycle_t c1, freq_div_t f1,
                               segment_t seg, rep_t r0, rep_t r1);
    cycle_0         = c0;
    freq_div_0      = f0;
    cycle_1         = c1;
    freq_div_1      = f1;
    req_segment     = seg;
    rep_0           = r0;
    rep_1           = r1;
    settings_update = 1'b1;
    step();
    settings_update = 1'b0;
    set_edge     = edge_cnt;
    mdl_cycle[0] = c0;
    mdl_cycle[1] = c1;
    mdl_fd[0]    = f0;
    mdl_fd[1]    = f1;
    mdl_rep[0]   = r0;
    mdl_rep[1]   = r1;
    mdl_seg      = seg;
    repeat (3) step();
  endtask

  // Pulses update, predicts the latched position and the burst it starts
  task automatic send_update();
    int m;
    update = 1'b1;
    step();
    update = 1'b0;
    m = edge_cnt - 1 - set_edge;
    if (!model_stop(m)) begin
      mdl_seq_idx = model_idx(m);
      mdl_seq_seg = mdl_seg;
    end
    for (int i = 0; i < LANES; i++) begin
      exp_edge.push_back(edge_cnt + 2 + i);
      exp_lane.push_back(i);
      exp_int.push_back(mdl_int[mdl_seq_seg][i][mdl_seq_idx]);
      exp_ph.push_back(mdl_ph[mdl_seq_seg][i][mdl_seq_idx]);
    end
    n_checks++;
    if (dbg_idx !== mdl_seq_idx || dbg_segment !== mdl_seq_seg) begin
      n_errors++;
      $display("error %0d ns: latched segment %0d index %0d, expected segment %0d index %0d",
               $time, dbg_segment, dbg_idx, mdl_seq_seg, mdl_seq_idx);
    end
  endtask

  always @(negedge CLK) begin
    if (rst_n) begin
      if (exp_edge.size() != 0 && exp_edge[0] == edge_cnt) begin
        n_checks++;
        if (dout_valid !== 1'b1) begin
          n_errors++;
          $display("error %0d ns: dout_valid low for lane %0d word", $time, exp_lane[0]);
        end else if (intensity !== exp_int[0] || phase !== exp_ph[0]) begin
          n_errors++;
          $display("error %0d ns: lane %0d got %h/%h, expected %h/%h", $time, exp_lane[0],
                   intensity, phase, exp_int[0], exp_ph[0]);
        end
        void'(exp_edge.pop_front());
        void'(exp_lane.pop_front());
        void'(exp_int.pop_front());
        void'(exp_ph.pop_front());
      end else if (dout_valid !== 1'b0) begin
        n_errors++;
        $display("error %0d ns: dout_valid high outside an expected burst", $time);
      end
    end
  end

  initial begin
    idx_t     prev_idx;
    int       idx_changes;
    rep_t     rep;
    segment_t seg;
    cycle_t   c0;
    cycle_t   c1;

    seed            = 32'had74;
    rst_n           = 1'b0;
    settings_update = 1'b0;
    cycle_0         = '0;
    freq_div_0      = '0;
    cycle_1         = '0;
    freq_div_1      = '0;
    req_segment     = '0;
    rep_0           = '0;
    rep_1           = '0;
    update          = 1'b0;
    wr_en           = 1'b0;
    wr_lane         = '0;
    wr_segment      = '0;
    wr_addr         = '0;
    wr_intensity    = '0;
    wr_phase        = '0;
    mdl_seq_idx     = '0;
    mdl_seq_seg     = '0;
    set_edge        = 0;
    repeat (10) @(posedge CLK);
    #2;
    rst_n = 1'b1;
    step();

    // Fill both segments of every lane with random pairs
    for (int s = 0; s < 2; s++) begin
      for (int l = 0; l < LANES; l++) begin
        for (int a = 0; a < MAXC; a++) begin
          wr_en        = 1'b1;
          wr_lane      = LANE_W'(l);
          wr_segment   = segment_t'(s);
          wr_addr      = idx_t'(a);
          wr_intensity = intensity_t'($random(seed));
          wr_phase     = phase_t'($random(seed));
          mdl_int[s][l][a] = wr_intensity;
          mdl_ph[s][l][a]  = wr_phase;
          step();
        end
      end
    end
    wr_en = 1'b0;

    // Readback, index stepping and segment switching while playing forever
    for (int r = 0; r < N_ROUNDS; r++) begin
      load_settings(cycle_t'(rand_range(2, MAXC)), freq_div_t'(rand_range(1, 8)),
                    cycle_t'(rand_range(2, MAXC)), freq_div_t'(rand_range(1, 8)),
                    segment_t'(r % 2), '1, '1);
      for (int j = 0; j < N_UPD; j++) begin
        send_update();
        repeat (rand_range(7, MAX_GAP) - 1) step();
      end
    end

    // Repetition limit with infinite repetition in the last run
    for (int r = 0; r < N_STOP; r++) begin
      rep = (r == N_STOP - 1) ? '1 : rep_t'(rand_range(0, 2));
      seg = segment_t'(rand_range(0, 1));
      c0  = cycle_t'(rand_range(2, 6));
      c1  = cycle_t'(rand_range(2, 6));
      load_settings(c0, 16'd8, c1, 16'd8, seg, rep, rep);
      prev_idx    = dbg_idx;
      idx_changes = 0;
      for (int j = 0; j < N_STOP_UPD; j++) begin
        send_update();
        // Only the late updates show whether indexing keeps running
        if (j >= N_STOP_UPD / 2 && dbg_idx != prev_idx) begin
          idx_changes++;
        end
        prev_idx = dbg_idx;
        repeat (rand_range(7, STOP_GAP_MAX) - 1) step();
      end
      n_checks++;
      if (rep != '1) begin
        if (dbg_idx !== (seg ? c1 : c0) - 16'd1) begin
          n_errors++;
          $display("error %0d ns: stopped index %0d is not the last entry", $time, dbg_idx);
        end
      end else if (idx_changes == 0) begin
        n_errors++;
        $display("error %0d ns: indexing stopped although repetition is infinite", $time);
      end
    end

    while (exp_edge.size() != 0) begin
      step();
    end
    repeat (4) step();

    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
